//--- cpu_settings.svh
/*
 * Core configuration for the 16-bit credit-fed pipeline.
 * Datapath and register widths, queue depth and the
 * credit counts on both links.
 */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and instruction word
`define DATA_W 16

// Register file
`define REG_IDX_W 3
`define REG_CNT 8

// Instruction queue entries, also the sender's starting credits
`define QUEUE_DEPTH 4

// Store link credits held by the core after reset
`define STORE_CREDITS 2

// Wide enough for QUEUE_DEPTH and STORE_CREDITS
`define CREDIT_W 3

`endif

//--- cpu_pkg.sv
/*
 * Shared types for the pipeline.
 * Data and instruction words, register numbers, the
 * opcode encoding and the execute operations.
 */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`DATA_W-1:0] instr_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	// Opcode field, bits 15 to 11
	typedef enum logic [4:0] {
		NOP   = 5'b00001,
		ADDI  = 5'b01000,
		SUBI  = 5'b01001,
		XORI  = 5'b01010,
		ANDNI = 5'b01011,
		ST    = 5'b10000,
		SLBI  = 5'b10010,
		LBI   = 5'b11000,
		ALU_R = 5'b11011
	} op_code_e;

	// Operation carried from decode to execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS_B,
		ALU_SLBI
	} alu_op_e;

endpackage

`default_nettype wire

//--- instr_queue.sv
/*
 * Instruction input queue.
 * Circular buffer filled by the outside sender, drained into
 * decode one word per cycle. Every issue returns a credit.
 */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module instr_queue (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            instr_valid,
	input  wire cpu_pkg::instr_t instr,
	input  wire logic            stall,
	output logic                 head_valid,
	output cpu_pkg::instr_t      head_instr,
	output logic                 instr_credit
);
	import cpu_pkg::*;

	localparam int DEPTH = `QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = `CREDIT_W;

	instr_t buffer [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// Sender credits guarantee a free slot on every push
	assign push = instr_valid;
	assign pop = (count != '0) && !stall;

	assign head_valid = (count != '0);
	assign head_instr = buffer[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			buffer[wr_ptr] <= instr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			instr_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
			// One credit back per word handed to decode
			instr_credit <= pop;
		end
	end

endmodule

`default_nettype wire

//--- register_file.sv
/*
 * Eight-entry register file.
 * Two combinational read ports and one write port; a read of
 * the register being written returns the new value.
 */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module register_file (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire cpu_pkg::reg_idx_t rd_idx_a,
	input  wire cpu_pkg::reg_idx_t rd_idx_b,
	input  wire cpu_pkg::reg_idx_t wr_idx,
	input  wire logic              wr_en,
	input  wire cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t         rd_data_a,
	output cpu_pkg::word_t         rd_data_b
);
	import cpu_pkg::*;

	word_t regs [`REG_CNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through so decode sees the writeback result this cycle
	assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- decode_stage.sv
/*
 * Decode stage.
 * Decodes the queue head, picks operands from the register
 * file or the execute result, and loads the decode/execute
 * register. Illegal opcodes turn into bubbles and set err.
 */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module decode_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              stall,
	input  wire logic              head_valid,
	input  wire cpu_pkg::instr_t   head_instr,
	input  wire cpu_pkg::word_t    rd_data_a,
	input  wire cpu_pkg::word_t    rd_data_b,
	input  wire cpu_pkg::word_t    ex_fwd_data,
	input  wire cpu_pkg::reg_idx_t ex_fwd_idx,
	input  wire logic              ex_fwd_en,
	output cpu_pkg::reg_idx_t      rd_idx_a,
	output cpu_pkg::reg_idx_t      rd_idx_b,
	output logic                   ex_valid,
	output cpu_pkg::alu_op_e       ex_op,
	output cpu_pkg::word_t         ex_a,
	output cpu_pkg::word_t         ex_b,
	output cpu_pkg::word_t         ex_store_data,
	output cpu_pkg::reg_idx_t      ex_dest,
	output logic                   ex_wen,
	output logic                   ex_store,
	output logic                   err
);
	import cpu_pkg::*;

	op_code_e opcode;
	alu_op_e dec_op;
	word_t imm5_s;
	word_t imm5_z;
	word_t imm8_s;
	word_t imm8_z;
	word_t opnd_a;
	word_t opnd_b;
	word_t dec_b;
	reg_idx_t dec_dest;
	logic dec_wen;
	logic dec_store;
	logic legal;

	assign opcode = op_code_e'(head_instr[15:11]);

	// Rs and the second register field sit at fixed positions
	assign rd_idx_a = head_instr[10:8];
	assign rd_idx_b = head_instr[7:5];

	assign imm5_s = {{(`DATA_W-5){head_instr[4]}}, head_instr[4:0]};
	assign imm5_z = {{(`DATA_W-5){1'b0}}, head_instr[4:0]};
	assign imm8_s = {{(`DATA_W-8){head_instr[7]}}, head_instr[7:0]};
	assign imm8_z = {{(`DATA_W-8){1'b0}}, head_instr[7:0]};

	// Execute result wins over the register file
	assign opnd_a = (ex_fwd_en && ex_fwd_idx == rd_idx_a) ? ex_fwd_data : rd_data_a;
	assign opnd_b = (ex_fwd_en && ex_fwd_idx == rd_idx_b) ? ex_fwd_data : rd_data_b;

	always_comb begin
		dec_op = ALU_ADD;
		dec_b = opnd_b;
		dec_dest = head_instr[7:5];
		dec_wen = 1'b1;
		dec_store = 1'b0;
		legal = 1'b1;
		case (opcode)
			NOP: dec_wen = 1'b0;
			ADDI: dec_b = imm5_s;
			SUBI: begin
				dec_op = ALU_SUB;
				dec_b = imm5_s;
			end
			XORI: begin
				dec_op = ALU_XOR;
				dec_b = imm5_z;
			end
			ANDNI: begin
				dec_op = ALU_ANDN;
				dec_b = imm5_z;
			end
			// Address is Rs plus imm5, data comes from bits 7 to 5
			ST: begin
				dec_b = imm5_s;
				dec_wen = 1'b0;
				dec_store = 1'b1;
			end
			LBI: begin
				dec_op = ALU_PASS_B;
				dec_b = imm8_s;
				dec_dest = head_instr[10:8];
			end
			SLBI: begin
				dec_op = ALU_SLBI;
				dec_b = imm8_z;
				dec_dest = head_instr[10:8];
			end
			ALU_R: begin
				dec_dest = head_instr[4:2];
				case (head_instr[1:0])
					2'b00: dec_op = ALU_ADD;
					2'b01: dec_op = ALU_SUB;
					2'b10: dec_op = ALU_XOR;
					default: dec_op = ALU_ANDN;
				endcase
			end
			default: begin
				dec_wen = 1'b0;
				legal = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_wen <= 1'b0;
			ex_store <= 1'b0;
			err <= 1'b0;
		end else if (!stall) begin
			ex_valid <= head_valid && legal;
			ex_wen <= dec_wen;
			ex_store <= dec_store;
			// Sticky until reset
			if (head_valid && !legal)
				err <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_op <= dec_op;
			ex_a <= opnd_a;
			ex_b <= dec_b;
			ex_store_data <= opnd_b;
			ex_dest <= dec_dest;
		end
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
/*
 * Execute stage.
 * ALU on the decoded operands, result forwarded back to
 * decode, and the execute/writeback register.
 */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              stall,
	input  wire logic              ex_valid,
	input  wire cpu_pkg::alu_op_e  ex_op,
	input  wire cpu_pkg::word_t    ex_a,
	input  wire cpu_pkg::word_t    ex_b,
	input  wire cpu_pkg::word_t    ex_store_data,
	input  wire cpu_pkg::reg_idx_t ex_dest,
	input  wire logic              ex_wen,
	input  wire logic              ex_store,
	output cpu_pkg::word_t         ex_fwd_data,
	output cpu_pkg::reg_idx_t      ex_fwd_idx,
	output logic                   ex_fwd_en,
	output logic                   wb_wen,
	output cpu_pkg::reg_idx_t      wb_idx,
	output cpu_pkg::word_t         wb_data,
	output logic                   wb_store,
	output cpu_pkg::word_t         wb_store_data
);
	import cpu_pkg::*;

	word_t result;

	always_comb begin
		case (ex_op)
			ALU_ADD: result = ex_a + ex_b;
			// Subtract is reversed, B minus A
			ALU_SUB: result = ex_b - ex_a;
			ALU_XOR: result = ex_a ^ ex_b;
			ALU_ANDN: result = ex_a & ~ex_b;
			ALU_SLBI: result = (ex_a << 8) | ex_b;
			default: result = ex_b;
		endcase
	end

	// For stores the result is the address and is never forwarded
	assign ex_fwd_data = result;
	assign ex_fwd_idx = ex_dest;
	assign ex_fwd_en = ex_valid && ex_wen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_wen <= 1'b0;
			wb_store <= 1'b0;
		end else if (!stall) begin
			wb_wen <= ex_valid && ex_wen;
			wb_store <= ex_valid && ex_store;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_idx <= ex_dest;
			wb_data <= result;
			wb_store_data <= ex_store_data;
		end
	end

endmodule

`default_nettype wire

//--- store_port.sv
/*
 * Store output port.
 * Sends writeback stores to the data memory link while a
 * credit is held, and stalls the pipeline when none is left.
 */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module store_port (
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire logic           wb_store,
	input  wire cpu_pkg::word_t wb_data,
	input  wire cpu_pkg::word_t wb_store_data,
	input  wire logic           store_credit,
	output logic                store_valid,
	output cpu_pkg::word_t      store_addr,
	output cpu_pkg::word_t      store_data,
	output logic                stall
);
	localparam int CREDIT_W = `CREDIT_W;
	localparam int INIT_CREDITS = `STORE_CREDITS;

	logic [CREDIT_W-1:0] credits;
	logic have_credit;

	assign have_credit = (credits != '0);

	assign store_valid = wb_store && have_credit;
	assign store_addr = wb_data;
	assign store_data = wb_store_data;

	// Hold the whole pipe until the sink returns a credit
	assign stall = wb_store && !have_credit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credits <= CREDIT_W'(INIT_CREDITS);
		else
			credits <= credits - CREDIT_W'(store_valid) + CREDIT_W'(store_credit);
	end

endmodule

`default_nettype wire

//--- cpu_top.sv
/*
 * Top level of the credit-fed 16-bit pipeline.
 * Instruction queue, decode with register file, execute and
 * the store port, wired as a three-stage pipe.
 */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            instr_valid,
	input  wire cpu_pkg::instr_t instr,
	input  wire logic            store_credit,
	output logic                 instr_credit,
	output logic                 store_valid,
	output cpu_pkg::word_t       store_addr,
	output cpu_pkg::word_t       store_data,
	output logic                 err
);
	import cpu_pkg::*;

	logic stall;

	// Queue to decode
	logic head_valid;
	instr_t head_instr;

	// Register file ports
	reg_idx_t rd_idx_a;
	reg_idx_t rd_idx_b;
	word_t rd_data_a;
	word_t rd_data_b;

	// Decode/execute register
	logic ex_valid;
	alu_op_e ex_op;
	word_t ex_a;
	word_t ex_b;
	word_t ex_store_data;
	reg_idx_t ex_dest;
	logic ex_wen;
	logic ex_store;

	// Execute result back to decode
	word_t ex_fwd_data;
	reg_idx_t ex_fwd_idx;
	logic ex_fwd_en;

	// Writeback register
	logic wb_wen;
	reg_idx_t wb_idx;
	word_t wb_data;
	logic wb_store;
	word_t wb_store_data;

	instr_queue u_instr_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.stall        (stall),
		.head_valid   (head_valid),
		.head_instr   (head_instr),
		.instr_credit (instr_credit)
	);

	decode_stage u_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.head_valid    (head_valid),
		.head_instr    (head_instr),
		.rd_data_a     (rd_data_a),
		.rd_data_b     (rd_data_b),
		.ex_fwd_data   (ex_fwd_data),
		.ex_fwd_idx    (ex_fwd_idx),
		.ex_fwd_en     (ex_fwd_en),
		.rd_idx_a      (rd_idx_a),
		.rd_idx_b      (rd_idx_b),
		.ex_valid      (ex_valid),
		.ex_op         (ex_op),
		.ex_a          (ex_a),
		.ex_b          (ex_b),
		.ex_store_data (ex_store_data),
		.ex_dest       (ex_dest),
		.ex_wen        (ex_wen),
		.ex_store      (ex_store),
		.err           (err)
	);

	register_file u_register_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.wr_idx    (wb_idx),
		.wr_en     (wb_wen),
		.wr_data   (wb_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	execute_stage u_execute_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.ex_valid      (ex_valid),
		.ex_op         (ex_op),
		.ex_a          (ex_a),
		.ex_b          (ex_b),
		.ex_store_data (ex_store_data),
		.ex_dest       (ex_dest),
		.ex_wen        (ex_wen),
		.ex_store      (ex_store),
		.ex_fwd_data   (ex_fwd_data),
		.ex_fwd_idx    (ex_fwd_idx),
		.ex_fwd_en     (ex_fwd_en),
		.wb_wen        (wb_wen),
		.wb_idx        (wb_idx),
		.wb_data       (wb_data),
		.wb_store      (wb_store),
		.wb_store_data (wb_store_data)
	);

	store_port u_store_port (
		.clk           (clk),
		.rst_n         (rst_n),
		.wb_store      (wb_store),
		.wb_data       (wb_data),
		.wb_store_data (wb_store_data),
		.store_credit  (store_credit),
		.store_valid   (store_valid),
		.store_addr    (store_addr),
		.store_data    (store_data),
		.stall         (stall)
	);

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
/*
 * Directed testbench for the credit-fed 16-bit pipeline.
 * Feeds instructions under input credits, models the register
 * file, and compares each store on the output link.
 */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu_top;
	import cpu_pkg::*;

	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic instr_valid;
	instr_t instr;
	logic store_credit = 1'b0;
	logic instr_credit;
	logic store_valid;
	word_t store_addr;
	word_t store_data;
	logic err;

	// Sender and sink bookkeeping
	int sent = 0;
	int credits_back = 0;
	int stores_seen = 0;
	int credits_returned = 0;
	logic hold_credits = 1'b0;

	word_t model_regs [`REG_CNT];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t obs_addr [$];
	word_t obs_data [$];

	logic [31:0] lcg_state = 32'h82a5;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	string cur_test = "";
	logic aborted = 1'b0;

	cpu_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.store_credit (store_credit),
		.instr_credit (instr_credit),
		.store_valid  (store_valid),
		.store_addr   (store_addr),
		.store_data   (store_data),
		.err          (err)
	);

	always #2 clk = ~clk;

	// Outputs are stable mid-cycle
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (instr_credit)
				credits_back = credits_back + 1;
			if (store_valid) begin
				obs_addr.push_back(store_addr);
				obs_data.push_back(store_data);
				stores_seen = stores_seen + 1;
			end
		end
	end

	task automatic return_store_credit();
		if (rst_n !== 1'b1) begin
			store_credit <= 1'b0;
		end else if (!hold_credits && credits_returned < stores_seen) begin
			store_credit <= 1'b1;
			credits_returned <= credits_returned + 1;
		end else begin
			store_credit <= 1'b0;
		end
	endtask

	always @(posedge clk)
		return_store_credit();

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic instr_t make_i_type(input op_code_e op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [4:0] imm5);
		return {op, rs, rt, imm5};
	endfunction

	function automatic instr_t make_r_type(input reg_idx_t rs, input reg_idx_t rt,
			input reg_idx_t rd, input logic [1:0] funct);
		return {ALU_R, rs, rt, rd, funct};
	endfunction

	function automatic instr_t make_b_type(input op_code_e op, input reg_idx_t rs,
			input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	// Reference semantics applied in program order at send time
	task automatic model_apply(input instr_t w);
		op_code_e op;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t a;
		word_t b;
		word_t imm5s;
		word_t imm5z;
		op = op_code_e'(w[15:11]);
		rs = w[10:8];
		rt = w[7:5];
		a = model_regs[rs];
		b = model_regs[rt];
		imm5s = {{(`DATA_W-5){w[4]}}, w[4:0]};
		imm5z = {{(`DATA_W-5){1'b0}}, w[4:0]};
		case (op)
			LBI: model_regs[rs] = {{(`DATA_W-8){w[7]}}, w[7:0]};
			SLBI: model_regs[rs] = {a[7:0], w[7:0]};
			ADDI: model_regs[rt] = a + imm5s;
			SUBI: model_regs[rt] = imm5s - a;
			XORI: model_regs[rt] = a ^ imm5z;
			ANDNI: model_regs[rt] = a & ~imm5z;
			ST: begin
				exp_addr.push_back(a + imm5s);
				exp_data.push_back(b);
			end
			ALU_R: begin
				case (w[1:0])
					2'b00: model_regs[w[4:2]] = a + b;
					2'b01: model_regs[w[4:2]] = b - a;
					2'b10: model_regs[w[4:2]] = a ^ b;
					default: model_regs[w[4:2]] = a & ~b;
				endcase
			end
			default: ;
		endcase
	endtask

	task automatic fail_wait(input string msg);
		$display("%s", msg);
		errors++;
		aborted = 1'b1;
	endtask

	task automatic check_store(input string name, input word_t e_addr, input word_t e_data,
			input word_t a_addr, input word_t a_data);
		checks++;
		if (e_addr !== a_addr || e_data !== a_data) begin
			errors++;
			$display("ERROR %s: expected addr %h data %h, actual addr %h data %h",
				name, e_addr, e_data, a_addr, a_data);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s %s: expected %b, actual %b",
				cur_test, name, expected, actual);
		end
	endtask

	// Holds instr_valid low while the sender has no credit
	task automatic send_instr(input instr_t word);
		int waited;
		waited = 0;
		@(posedge clk);
		while (`QUEUE_DEPTH - sent + credits_back <= 0 && !aborted) begin
			instr_valid <= 1'b0;
			@(posedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait("timed out waiting for an instruction credit");
		end
		if (!aborted) begin
			instr_valid <= 1'b1;
			instr <= word;
			sent++;
			model_apply(word);
		end
	endtask

	task automatic stop_sending();
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic drain_stores(input string name);
		int waited;
		stop_sending();
		waited = 0;
		while (obs_addr.size() < exp_addr.size() && !aborted) begin
			@(posedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait($sformatf("%s: expected stores never appeared", name));
		end
		waited = 0;
		while (credits_returned < stores_seen && !aborted) begin
			@(posedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait($sformatf("%s: store credits were not returned", name));
		end
		while (exp_addr.size() > 0 && obs_addr.size() > 0)
			check_store(name, exp_addr.pop_front(), exp_data.pop_front(),
				obs_addr.pop_front(), obs_data.pop_front());
		if (obs_addr.size() != 0) begin
			errors++;
			$display("%s: the core sent %0d stores that the program did not contain",
				name, obs_addr.size());
			obs_addr.delete();
			obs_data.delete();
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_start_errors) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, errors - test_start_errors);
		end
	endtask

	task automatic test_reset_and_credits();
		int waited;
		int base;
		begin_test("reset_and_credits");
		@(negedge clk);
		check_flag("reset store_valid", 1'b0, store_valid);
		check_flag("reset instr_credit", 1'b0, instr_credit);
		check_flag("reset err", 1'b0, err);
		base = credits_back;
		for (int i = 0; i < `QUEUE_DEPTH; i++)
			send_instr(make_b_type(NOP, 3'd0, 8'h00));
		stop_sending();
		waited = 0;
		while (credits_back < sent && !aborted) begin
			@(posedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait("credits: instruction credits were not all returned");
		end
		// Extra pulses would show up within this window
		repeat (10) @(posedge clk);
		check_flag("credits returned", 1'b1, (credits_back - base) == `QUEUE_DEPTH);
		end_test();
	endtask

	task automatic test_immediates();
		begin_test("immediates");
		send_instr(make_b_type(LBI, 3'd1, 8'hA5));
		send_instr(make_i_type(ST, 3'd0, 3'd1, 5'd0));
		send_instr(make_b_type(SLBI, 3'd1, 8'h3C));
		send_instr(make_i_type(ST, 3'd0, 3'd1, 5'd1));
		send_instr(make_i_type(ADDI, 3'd1, 3'd2, 5'h1D));
		send_instr(make_i_type(ST, 3'd0, 3'd2, 5'd2));
		send_instr(make_i_type(SUBI, 3'd2, 3'd3, 5'h13));
		send_instr(make_i_type(ST, 3'd1, 3'd3, 5'h1F));
		send_instr(make_i_type(XORI, 3'd3, 3'd4, 5'h1F));
		send_instr(make_i_type(ST, 3'd0, 3'd4, 5'd4));
		send_instr(make_i_type(ANDNI, 3'd4, 3'd5, 5'h16));
		send_instr(make_i_type(ST, 3'd0, 3'd5, 5'd5));
		drain_stores("immediates");
		end_test();
	endtask

	task automatic test_dependent_chains();
		begin_test("dependent_chains");
		send_instr(make_b_type(LBI, 3'd1, 8'h07));
		send_instr(make_b_type(LBI, 3'd2, 8'hFE));
		for (int i = 0; i < 2; i++) begin
			send_instr(make_r_type(3'd1, 3'd2, 3'd3, 2'b00));
			send_instr(make_r_type(3'd3, 3'd1, 3'd4, 2'b01));
			send_instr(make_r_type(3'd4, 3'd3, 3'd5, 2'b10));
			send_instr(make_r_type(3'd5, 3'd4, 3'd6, 2'b11));
			send_instr(make_r_type(3'd6, 3'd5, 3'd1, 2'b00));
		end
		for (int r = 1; r < 7; r++)
			send_instr(make_i_type(ST, 3'd0, reg_idx_t'(r), 5'(r)));
		drain_stores("dependent_chains");
		end_test();
	endtask

	task automatic test_store_backpressure();
		int waited;
		begin_test("store_backpressure");
		hold_credits <= 1'b1;
		send_instr(make_b_type(LBI, 3'd7, 8'h40));
		for (int r = 1; r < 6; r++)
			send_instr(make_i_type(ST, 3'd7, reg_idx_t'(r), 5'(r)));
		stop_sending();
		waited = 0;
		while (obs_addr.size() < `STORE_CREDITS && !aborted) begin
			@(posedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait("backpressure: first stores never appeared");
		end
		repeat (20) @(posedge clk);
		check_flag("stores before credit return", 1'b1, obs_addr.size() == `STORE_CREDITS);
		hold_credits <= 1'b0;
		drain_stores("store_backpressure");
		end_test();
	endtask

	function automatic op_code_e pick_opcode(input logic [2:0] sel);
		case (sel)
			3'd0: return ADDI;
			3'd1: return SUBI;
			3'd2: return XORI;
			3'd3: return ANDNI;
			3'd4: return SLBI;
			3'd5: return LBI;
			3'd6: return ALU_R;
			default: return ST;
		endcase
	endfunction

	task automatic test_random_program();
		logic [31:0] r;
		begin_test("random_program");
		for (int i = 0; i < 50; i++) begin
			r = lcg_next();
			send_instr({pick_opcode(r[18:16]), r[29:19]});
		end
		for (int k = 0; k < `REG_CNT; k++)
			send_instr(make_i_type(ST, 3'd0, reg_idx_t'(k), 5'(k)));
		drain_stores("random_program");
		end_test();
	endtask

	task automatic test_illegal_opcode();
		int waited;
		begin_test("illegal_opcode");
		@(negedge clk);
		check_flag("err before illegal", 1'b0, err);
		send_instr(make_b_type(LBI, 3'd2, 8'h11));
		// Dropped reference opcodes with fields shaped like writes to r2
		send_instr({5'b00000, 3'd2, 3'd2, 5'h03});
		send_instr({5'b11100, 3'd2, 3'd2, 3'd2, 2'b00});
		send_instr(make_i_type(ST, 3'd0, 3'd2, 5'd9));
		stop_sending();
		waited = 0;
		while (err !== 1'b1 && !aborted) begin
			@(negedge clk);
			waited++;
			if (waited >= TIMEOUT)
				fail_wait("illegal_opcode: err never went high");
		end
		drain_stores("illegal_opcode");
		send_instr(make_b_type(NOP, 3'd0, 8'h00));
		drain_stores("illegal_opcode");
		@(negedge clk);
		check_flag("err sticky", 1'b1, err);
		end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		for (int i = 0; i < `REG_CNT; i++)
			model_regs[i] = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_and_credits();
		test_immediates();
		test_dependent_chains();
		test_store_backpressure();
		test_random_program();
		test_illegal_opcode();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
cpu_pkg.sv
instr_queue.sv
register_file.sv
decode_stage.sv
execute_stage.sv
store_port.sv
cpu_top.sv
tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
